/* flist.f */
adc_cfg_pkg.sv
adc_seq_pkg.sv
adc_seq_fsm.sv
adc_sample_eval.sv
adc_ctrl_core.sv
tb_adc_ctrl_core.sv

/* Makefile */
# Verilator build and run of the ADC controller testbench
VERILATOR ?= verilator
TOP       ?= tb_adc_ctrl_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_adc_ctrl_core.sv */
// table-driven testbench for adc_ctrl_core with a behavioral converter
// converter answers each channel select after 1 to 6 random cycles
// match history survives an enable fall, so rows use distinct match vectors

`default_nettype none

module tb_adc_ctrl_core;

  // one stimulus row, expected values worked out by hand
  typedef struct packed {
    logic                     oneshot;
    adc_cfg_pkg::pwrup_time_t pwrup;
    adc_cfg_pkg::sample_cnt_t cnt;
    adc_cfg_pkg::adc_data_t   d0;
    adc_cfg_pkg::adc_data_t   d1;
    adc_cfg_pkg::adc_match_t  match;
    adc_cfg_pkg::adc_match_t  match2;
    int                       chg_at;
    int                       n_evals;
    logic                     end_rst;
    int                       exp_pd_cycles;
    int                       exp_dones;
  } stim_row_t;

  logic                      clk_aon;
  logic                      rst_aon_n;
  logic                      cfg_fsm_rst;
  logic                      cfg_adc_enable;
  logic                      cfg_oneshot_mode;
  adc_cfg_pkg::pwrup_time_t  cfg_pwrup_time;
  adc_cfg_pkg::sample_cnt_t  cfg_np_sample_cnt;
  adc_cfg_pkg::adc_match_t   adc_ctrl_match;
  adc_cfg_pkg::adc_data_t    adc_d;
  logic                      adc_d_val;
  logic                      adc_pd;
  adc_cfg_pkg::adc_chn_sel_t adc_chn_sel;
  logic                      chn0_val_we;
  logic                      chn1_val_we;
  adc_cfg_pkg::adc_data_t    chn0_val;
  adc_cfg_pkg::adc_data_t    chn1_val;
  logic                      adc_ctrl_done;
  logic                      oneshot_done;

  stim_row_t rows [0:5];
  string     names [0:5];
  stim_row_t cur;
  string     cur_name;
  int        errors;
  int        test_err_start;
  int        n_pass;
  int        n_fail;
  logic      timed_out;

  // per-cycle bookkeeping, updated in step only
  logic                      prev_val;
  logic                      prev_rst;
  adc_cfg_pkg::adc_chn_sel_t prev_sel;
  logic                      eval_seen;
  int                        n_we0;
  int                        n_we1;
  int                        n_os_done;
  int                        n_done;
  int                        eval_idx;
  int                        chg_idx;

  adc_ctrl_core UUT (
    .clk_aon_i           (clk_aon),
    .rst_aon_ni          (rst_aon_n),
    .cfg_fsm_rst_i       (cfg_fsm_rst),
    .cfg_adc_enable_i    (cfg_adc_enable),
    .cfg_oneshot_mode_i  (cfg_oneshot_mode),
    .cfg_pwrup_time_i    (cfg_pwrup_time),
    .cfg_np_sample_cnt_i (cfg_np_sample_cnt),
    .adc_ctrl_match_i    (adc_ctrl_match),
    .adc_d_i             (adc_d),
    .adc_d_val_i         (adc_d_val),
    .adc_pd_o            (adc_pd),
    .adc_chn_sel_o       (adc_chn_sel),
    .chn0_val_we_o       (chn0_val_we),
    .chn1_val_we_o       (chn1_val_we),
    .chn0_val_o          (chn0_val),
    .chn1_val_o          (chn1_val),
    .adc_ctrl_done_o     (adc_ctrl_done),
    .oneshot_done_o      (oneshot_done)
  );

  initial begin
    clk_aon = 1'b0;
    forever #10 clk_aon = ~clk_aon;
  end

  // converter model
  // sees a select at negedge, answers with one valid pulse a few edges later
  initial begin : converter_model
    int unsigned               delay;
    adc_cfg_pkg::adc_chn_sel_t sel;
    adc_d_val <= 1'b0;
    adc_d     <= '0;
    forever begin
      @(negedge clk_aon);
      if (!adc_pd && (adc_chn_sel != adc_cfg_pkg::ChnSelNone)) begin
        sel   = adc_chn_sel;
        delay = 1 + ($urandom % 6);
        repeat (delay) @(posedge clk_aon);
        adc_d_val <= 1'b1;
        adc_d     <= (sel == adc_cfg_pkg::ChnSel0) ? cur.d0 : cur.d1;
        @(posedge clk_aon);
        adc_d_val <= 1'b0;
      end
    end
  end

  task automatic check_data(input string what, input adc_cfg_pkg::adc_data_t exp,
                            input adc_cfg_pkg::adc_data_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_sel(input string what, input adc_cfg_pkg::adc_chn_sel_t exp,
                           input adc_cfg_pkg::adc_chn_sel_t act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %b, actual %b at %0t", cur_name, what, exp, act, $time);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
    end
  endtask

  // remaining rows are skipped, the closing report then fails the run
  task automatic abort_run(input string what);
    errors++;
    timed_out = 1'b1;
    $display("%s: timed out waiting for %s", cur_name, what);
  endtask

  // done expected at evaluation c+N, then every N, c being the first eval with a new vector
  function automatic logic done_expected(input int e);
    int first;
    first = chg_idx + int'(cur.cnt);
    return (e >= first) && ((e - first) % int'(cur.cnt) == 0);
  endfunction

  // one clock, strobes checked against the previous cycle's valid and select
  task automatic step;
    logic exp_we0;
    logic exp_we1;
    logic exp_os;
    logic exp_done;
    @(negedge clk_aon);
    exp_we0 = prev_val && (prev_sel == adc_cfg_pkg::ChnSel0) && !prev_rst;
    exp_we1 = prev_val && (prev_sel == adc_cfg_pkg::ChnSel1) && !prev_rst;
    exp_os  = cfg_oneshot_mode && adc_d_val && (adc_chn_sel == adc_cfg_pkg::ChnSel1);
    // evaluation cycle coincides with the chn1 write strobe
    eval_seen = !cfg_oneshot_mode && chn1_val_we;
    exp_done  = 1'b0;
    if (eval_seen) begin
      eval_idx++;
      exp_done = done_expected(eval_idx);
    end
    check_bit("chn0 write strobe", exp_we0, chn0_val_we);
    check_bit("chn1 write strobe", exp_we1, chn1_val_we);
    check_bit("oneshot done", exp_os, oneshot_done);
    check_bit("detection done", exp_done, adc_ctrl_done);
    n_we0     += int'(chn0_val_we);
    n_we1     += int'(chn1_val_we);
    n_os_done += int'(oneshot_done);
    n_done    += int'(adc_ctrl_done);
    prev_val = adc_d_val;
    prev_sel = adc_chn_sel;
    prev_rst = cfg_fsm_rst;
  endtask

  // raise enable and count powered cycles before channel 0 shows up
  task automatic power_up;
    int n;
    int pd_cycles;
    n         = 0;
    pd_cycles = 0;
    @(posedge clk_aon);
    cfg_oneshot_mode  <= cur.oneshot;
    cfg_pwrup_time    <= cur.pwrup;
    cfg_np_sample_cnt <= cur.cnt;
    adc_ctrl_match    <= cur.match;
    cfg_adc_enable    <= 1'b1;
    do begin
      step;
      n++;
      if (!adc_pd && (adc_chn_sel == adc_cfg_pkg::ChnSelNone)) begin
        pd_cycles++;
      end
    end while ((adc_chn_sel != adc_cfg_pkg::ChnSel0) && (n < 40));
    if (adc_chn_sel != adc_cfg_pkg::ChnSel0) begin
      abort_run("channel 0 select after power-up");
    end else begin
      check_count("power-up cycles", cur.exp_pd_cycles, pd_cycles);
    end
  endtask

  task automatic run_oneshot;
    int n;
    n = 0;
    while (!adc_pd && (n < 100)) begin
      step;
      n++;
    end
    if (!adc_pd) begin
      abort_run("power-down after one-shot");
    end else begin
      check_count("chn0 write strobes", 1, n_we0);
      check_count("chn1 write strobes", 1, n_we1);
      check_count("oneshot done pulses", 1, n_os_done);
      check_data("chn0 result", cur.d0, chn0_val);
      check_data("chn1 result", cur.d1, chn1_val);
    end
  endtask

  task automatic run_normal;
    int n;
    n = 0;
    while ((eval_idx < cur.n_evals) && (n < 400)) begin
      step;
      n++;
      // new vector is first seen by the next evaluation
      if (eval_seen && (eval_idx == cur.chg_at)) begin
        @(posedge clk_aon);
        adc_ctrl_match <= cur.match2;
        chg_idx = eval_idx + 1;
      end
    end
    if (eval_idx < cur.n_evals) begin
      abort_run("normal-power evaluations");
    end else begin
      check_count("detection done pulses", cur.exp_dones, n_done);
      check_data("chn0 result", cur.d0, chn0_val);
      check_data("chn1 result", cur.d1, chn1_val);
    end
  endtask

  // enable fall or fsm reset, right after an evaluation so no sample is in flight
  task automatic power_down;
    int n;
    @(posedge clk_aon);
    if (cur.end_rst) begin
      cfg_fsm_rst <= 1'b1;
    end else begin
      cfg_adc_enable <= 1'b0;
    end
    n = 0;
    do begin
      step;
      n++;
    end while (!(adc_pd && (adc_chn_sel == adc_cfg_pkg::ChnSelNone)) && (n < 2));
    if (!adc_pd || (adc_chn_sel != adc_cfg_pkg::ChnSelNone)) begin
      errors++;
      $display("%s: converter still powered 2 cycles after power-down request", cur_name);
    end
    @(posedge clk_aon);
    cfg_fsm_rst    <= 1'b0;
    cfg_adc_enable <= 1'b0;
    step;
    if (cur.end_rst) begin
      check_data("chn0 result after fsm reset", '0, chn0_val);
      check_data("chn1 result after fsm reset", '0, chn1_val);
    end
    // lets a late converter pulse die out before the next row
    repeat (6) step;
  endtask

  task automatic report_test;
    if (errors == test_err_start) begin
      n_pass++;
      $display("test %s: pass", cur_name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", cur_name, errors - test_err_start);
    end
  endtask

  initial begin : main
    void'($urandom(40));
    rst_aon_n         <= 1'b1;
    cfg_fsm_rst       <= 1'b0;
    cfg_adc_enable    <= 1'b0;
    cfg_oneshot_mode  <= 1'b0;
    cfg_pwrup_time    <= '0;
    cfg_np_sample_cnt <= '0;
    adc_ctrl_match    <= '0;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    prev_val  = 1'b0;
    prev_rst  = 1'b0;
    prev_sel  = adc_cfg_pkg::ChnSelNone;
    cur       = '0;
    // oneshot pwrup cnt d0 d1 match match2 chg_at n_evals end_rst exp_pd exp_dones
    rows[0]  = '{1'b1, 4'd0, 16'd0, 10'h155, 10'h2aa, 8'h00, 8'h00, 0, 0, 1'b0, 2, 0};
    rows[1]  = '{1'b1, 4'd5, 16'd0, 10'h3ff, 10'h001, 8'h00, 8'h00, 0, 0, 1'b1, 7, 0};
    rows[2]  = '{1'b0, 4'd2, 16'd1, 10'h123, 10'h0ab, 8'h01, 8'h01, 0, 6, 1'b0, 4, 5};
    rows[3]  = '{1'b0, 4'd15, 16'd3, 10'h2c4, 10'h19e, 8'h5a, 8'h5a, 0, 10, 1'b1, 17, 3};
    rows[4]  = '{1'b0, 4'd1, 16'd2, 10'h0f0, 10'h30c, 8'h0f, 8'hf0, 4, 11, 1'b0, 3, 4};
    rows[5]  = '{1'b1, 4'd3, 16'd0, 10'h200, 10'h07f, 8'h00, 8'h00, 0, 0, 1'b0, 5, 0};
    names[0] = "oneshot_pw0";
    names[1] = "oneshot_pw5_fsm_rst";
    names[2] = "np_cnt1";
    names[3] = "np_cnt3_fsm_rst";
    names[4] = "np_match_change";
    names[5] = "oneshot_pw3";

    @(posedge clk_aon);
    rst_aon_n <= 1'b0;
    repeat (3) @(posedge clk_aon);
    rst_aon_n <= 1'b1;

    cur_name       = "after_reset";
    test_err_start = errors;
    step;
    check_bit("power-down level", 1'b1, adc_pd);
    check_sel("channel select", adc_cfg_pkg::ChnSelNone, adc_chn_sel);
    check_data("chn0 result", '0, chn0_val);
    check_data("chn1 result", '0, chn1_val);
    report_test;

    foreach (rows[i]) begin
      if (timed_out) begin
        break;
      end
      cur            = rows[i];
      cur_name       = names[i];
      test_err_start = errors;
      n_we0          = 0;
      n_we1          = 0;
      n_os_done      = 0;
      n_done         = 0;
      eval_idx       = 0;
      chg_idx        = 1;
      power_up;
      if (!timed_out) begin
        if (cur.oneshot) begin
          run_oneshot;
        end else begin
          run_normal;
        end
      end
      if (!timed_out) begin
        power_down;
      end
      report_test;
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* adc_ctrl_core.sv */
// always-on ADC controller, sequencer plus sample evaluation
// adc_d_i is only looked at with adc_d_val_i
// match vector is sampled in the evaluation cycle of normal-power mode

`default_nettype none

module adc_ctrl_core (
  input  logic                      clk_aon_i,
  input  logic                      rst_aon_ni,
  input  logic                      cfg_fsm_rst_i,
  input  logic                      cfg_adc_enable_i,
  input  logic                      cfg_oneshot_mode_i,
  input  adc_cfg_pkg::pwrup_time_t  cfg_pwrup_time_i,
  input  adc_cfg_pkg::sample_cnt_t  cfg_np_sample_cnt_i,
  input  adc_cfg_pkg::adc_match_t   adc_ctrl_match_i,
  input  adc_cfg_pkg::adc_data_t    adc_d_i,
  input  logic                      adc_d_val_i,
  output logic                      adc_pd_o,
  output adc_cfg_pkg::adc_chn_sel_t adc_chn_sel_o,
  output logic                      chn0_val_we_o,
  output logic                      chn1_val_we_o,
  output adc_cfg_pkg::adc_data_t    chn0_val_o,
  output adc_cfg_pkg::adc_data_t    chn1_val_o,
  output logic                      adc_ctrl_done_o,
  output logic                      oneshot_done_o
);

  // sequencer to evaluator
  logic chn0_sample;
  logic chn1_sample;
  logic np_eval;

  // power, channel select and the one-shot done
  adc_seq_fsm u_seq_fsm (
    .clk_aon_i          (clk_aon_i),
    .rst_aon_ni         (rst_aon_ni),
    .cfg_fsm_rst_i      (cfg_fsm_rst_i),
    .cfg_adc_enable_i   (cfg_adc_enable_i),
    .cfg_oneshot_mode_i (cfg_oneshot_mode_i),
    .cfg_pwrup_time_i   (cfg_pwrup_time_i),
    .adc_d_val_i        (adc_d_val_i),
    .adc_pd_o           (adc_pd_o),
    .adc_chn_sel_o      (adc_chn_sel_o),
    .chn0_sample_o      (chn0_sample),
    .chn1_sample_o      (chn1_sample),
    .np_eval_o          (np_eval),
    .oneshot_done_o     (oneshot_done_o)
  );

  // results and normal-power detection
  adc_sample_eval u_sample_eval (
    .clk_aon_i           (clk_aon_i),
    .rst_aon_ni          (rst_aon_ni),
    .cfg_fsm_rst_i       (cfg_fsm_rst_i),
    .cfg_np_sample_cnt_i (cfg_np_sample_cnt_i),
    .adc_d_i             (adc_d_i),
    .adc_ctrl_match_i    (adc_ctrl_match_i),
    .chn0_sample_i       (chn0_sample),
    .chn1_sample_i       (chn1_sample),
    .np_eval_i           (np_eval),
    .chn0_val_o          (chn0_val_o),
    .chn1_val_o          (chn1_val_o),
    .chn0_val_we_o       (chn0_val_we_o),
    .chn1_val_we_o       (chn1_val_we_o),
    .adc_ctrl_done_o     (adc_ctrl_done_o)
  );

endmodule

`default_nettype wire

/* adc_sample_eval.sv */
// result capture and normal-power stable-match detection
// relies on the sequencer for strobes, never sees states or adc_d_val_i
// history starts cleared, so an all-zero match vector counts as stable
// a sample count of zero never fires done

`default_nettype none

module adc_sample_eval (
  input  logic                     clk_aon_i,
  input  logic                     rst_aon_ni,
  input  logic                     cfg_fsm_rst_i,
  input  adc_cfg_pkg::sample_cnt_t cfg_np_sample_cnt_i,
  input  adc_cfg_pkg::adc_data_t   adc_d_i,
  input  adc_cfg_pkg::adc_match_t  adc_ctrl_match_i,
  input  logic                     chn0_sample_i,
  input  logic                     chn1_sample_i,
  input  logic                     np_eval_i,
  output adc_cfg_pkg::adc_data_t   chn0_val_o,
  output adc_cfg_pkg::adc_data_t   chn1_val_o,
  output logic                     chn0_val_we_o,
  output logic                     chn1_val_we_o,
  output logic                     adc_ctrl_done_o
);

  adc_cfg_pkg::adc_match_t  match_q;
  adc_cfg_pkg::sample_cnt_t sample_cnt_q;

  logic match_same;
  logic cnt_hit;
  logic cnt_clr;

  // result registers and write strobes
  // both show up one cycle after the valid pulse
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      chn0_val_o    <= '0;
      chn1_val_o    <= '0;
      chn0_val_we_o <= 1'b0;
      chn1_val_we_o <= 1'b0;
    end else if (cfg_fsm_rst_i) begin
      chn0_val_o    <= '0;
      chn1_val_o    <= '0;
      chn0_val_we_o <= 1'b0;
      chn1_val_we_o <= 1'b0;
    end else begin
      chn0_val_we_o <= chn0_sample_i;
      chn1_val_we_o <= chn1_sample_i;
      if (chn0_sample_i) begin
        chn0_val_o <= adc_d_i;
      end
      if (chn1_sample_i) begin
        chn1_val_o <= adc_d_i;
      end
    end
  end

  // compare against the vector seen in the previous evaluation
  assign match_same = (adc_ctrl_match_i == match_q);
  assign cnt_hit    = (sample_cnt_q == cfg_np_sample_cnt_i);

  // restart on a changed vector, or after a detection
  assign cnt_clr = np_eval_i && (!match_same || cnt_hit);

  assign adc_ctrl_done_o = np_eval_i && match_same && cnt_hit;

  // match history, refreshed in every evaluation cycle
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      match_q <= '0;
    end else if (cfg_fsm_rst_i) begin
      match_q <= '0;
    end else if (np_eval_i) begin
      match_q <= adc_ctrl_match_i;
    end
  end

  // one count per completed channel pair
  // increment and evaluation never fall in the same cycle
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sample_cnt_q <= '0;
    end else if (cfg_fsm_rst_i || cnt_clr) begin
      sample_cnt_q <= '0;
    end else if (chn1_sample_i) begin
      sample_cnt_q <= sample_cnt_q + 1'b1;
    end
  end

  // sequencer leaves a sampling state right after its valid, so no back-to-back
  chn0_we_pulse_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    chn0_val_we_o |=> !chn0_val_we_o);

  chn1_we_pulse_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    chn1_val_we_o |=> !chn1_val_we_o);

  // only one channel is ever being sampled
  chn_sample_onehot_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    !(chn0_sample_i && chn1_sample_i));

endmodule

`default_nettype wire

/* adc_seq_fsm.sv */
// ADC conversion sequencer, one-shot and normal-power modes
// enable edges are seen against a registered copy of the enable
// sampling states hold until adc_d_val_i, there is no timeout
// fsm reset parks in power-down until the next enable rising edge

`default_nettype none

module adc_seq_fsm (
  input  logic                      clk_aon_i,
  input  logic                      rst_aon_ni,
  input  logic                      cfg_fsm_rst_i,
  input  logic                      cfg_adc_enable_i,
  input  logic                      cfg_oneshot_mode_i,
  input  adc_cfg_pkg::pwrup_time_t  cfg_pwrup_time_i,
  input  logic                      adc_d_val_i,
  output logic                      adc_pd_o,
  output adc_cfg_pkg::adc_chn_sel_t adc_chn_sel_o,
  output logic                      chn0_sample_o,
  output logic                      chn1_sample_o,
  output logic                      np_eval_o,
  output logic                      oneshot_done_o
);

  logic trigger_q;
  logic trigger_l2h;
  logic trigger_h2l;

  adc_cfg_pkg::pwrup_time_t pwrup_cnt_q;
  logic                     pwrup_done;

  adc_seq_pkg::adc_seq_state_e state_q;
  adc_seq_pkg::adc_seq_state_e state_d;

  logic chn0_sel;
  logic chn1_sel;

  // enable edge detect
  // copy keeps tracking through fsm reset so a held enable does not retrigger
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      trigger_q <= 1'b0;
    end else begin
      trigger_q <= cfg_adc_enable_i;
    end
  end

  assign trigger_l2h = !trigger_q && cfg_adc_enable_i;
  assign trigger_h2l = trigger_q && !cfg_adc_enable_i;

  // power-up timer, runs only in PWRUP
  // counts 0 up to cfg_pwrup_time_i, so PWRUP lasts time+1 cycles
  assign pwrup_done = (pwrup_cnt_q == cfg_pwrup_time_i);

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      pwrup_cnt_q <= '0;
    end else if (cfg_fsm_rst_i || (state_q != adc_seq_pkg::PWRUP) || pwrup_done) begin
      pwrup_cnt_q <= '0;
    end else begin
      pwrup_cnt_q <= pwrup_cnt_q + 1'b1;
    end
  end

  // state register
  // enable fall and fsm reset win over the normal flow
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q <= adc_seq_pkg::SeqResetState;
    end else if (trigger_h2l || cfg_fsm_rst_i) begin
      state_q <= adc_seq_pkg::SeqResetState;
    end else begin
      state_q <= state_d;
    end
  end

  // next state and state-decoded outputs
  always_comb begin
    state_d        = state_q;
    adc_pd_o       = 1'b0;
    chn0_sel       = 1'b0;
    chn1_sel       = 1'b0;
    np_eval_o      = 1'b0;
    oneshot_done_o = 1'b0;

    case (state_q)
      adc_seq_pkg::PWRDN: begin
        adc_pd_o = 1'b1;
        if (trigger_l2h) begin
          state_d = adc_seq_pkg::PWRUP;
        end
      end

      adc_seq_pkg::PWRUP: begin
        if (pwrup_done) begin
          state_d = adc_seq_pkg::IDLE;
        end
      end

      // one cycle, mode picked here
      adc_seq_pkg::IDLE: begin
        if (cfg_oneshot_mode_i) begin
          state_d = adc_seq_pkg::ONEST_0;
        end else begin
          state_d = adc_seq_pkg::NP_0;
        end
      end

      adc_seq_pkg::ONEST_0: begin
        chn0_sel = 1'b1;
        if (adc_d_val_i) begin
          state_d = adc_seq_pkg::ONEST_021;
        end
      end

      // gap between channels, nothing selected
      adc_seq_pkg::ONEST_021: begin
        state_d = adc_seq_pkg::ONEST_1;
      end

      adc_seq_pkg::ONEST_1: begin
        chn1_sel = 1'b1;
        if (adc_d_val_i) begin
          // done rides on the channel 1 valid
          oneshot_done_o = 1'b1;
          state_d        = adc_seq_pkg::PWRDN;
        end
      end

      adc_seq_pkg::NP_0: begin
        chn0_sel = 1'b1;
        if (adc_d_val_i) begin
          state_d = adc_seq_pkg::NP_021;
        end
      end

      adc_seq_pkg::NP_021: begin
        state_d = adc_seq_pkg::NP_1;
      end

      adc_seq_pkg::NP_1: begin
        chn1_sel = 1'b1;
        if (adc_d_val_i) begin
          state_d = adc_seq_pkg::NP_EVAL;
        end
      end

      // match check happens in the evaluator during this cycle
      adc_seq_pkg::NP_EVAL: begin
        np_eval_o = 1'b1;
        state_d   = adc_seq_pkg::NP_0;
      end

      // unused low-power codes
      default: begin
        adc_pd_o = 1'b1;
        state_d  = adc_seq_pkg::PWRDN;
      end
    endcase
  end

  assign adc_chn_sel_o = chn0_sel ? adc_cfg_pkg::ChnSel0 :
                         chn1_sel ? adc_cfg_pkg::ChnSel1 :
                                    adc_cfg_pkg::ChnSelNone;

  // a sample is taken when the valid pulse lands in a sampling state
  assign chn0_sample_o = chn0_sel && adc_d_val_i;
  assign chn1_sample_o = chn1_sel && adc_d_val_i;

  // a select holds until its valid, unless power-down is forced
  chn_sel_hold_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    ((adc_chn_sel_o != adc_cfg_pkg::ChnSelNone) && !adc_d_val_i && !cfg_fsm_rst_i &&
     !trigger_h2l) |=> $stable(adc_chn_sel_o));

  // a powered-down converter gets no select in the cycle after either
  pd_no_chn_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    adc_pd_o |=> (adc_chn_sel_o == adc_cfg_pkg::ChnSelNone));

endmodule

`default_nettype wire

/* adc_seq_pkg.sv */
// sequencer state encoding
// codes 6 to b were the low-power states and stay unused here
// any unused code falls back to power-down in the sequencer

`default_nettype none

package adc_seq_pkg;

  localparam int unsigned StateWidth = 4;

  // flow of the two kept modes
  // one-shot: PWRDN, PWRUP, IDLE, ONEST_0, ONEST_021, ONEST_1, PWRDN
  // normal:   PWRDN, PWRUP, IDLE, NP_0, NP_021, NP_1, NP_EVAL, NP_0 ...
  typedef enum logic [StateWidth-1:0] {
    // converter off
    PWRDN     = 4'h0,
    // waiting out the power-up time
    PWRUP     = 4'h1,
    // powered, mode is chosen here
    IDLE      = 4'h2,
    // one-shot sampling
    ONEST_0   = 4'h3,
    ONEST_021 = 4'h4,
    ONEST_1   = 4'h5,
    // normal-power sampling and evaluation
    NP_0      = 4'hc,
    NP_021    = 4'hd,
    NP_1      = 4'he,
    NP_EVAL   = 4'hf
  } adc_seq_state_e;

  // state after reset, fsm reset or enable fall
  localparam adc_seq_state_e SeqResetState = PWRDN;

endpackage

`default_nettype wire

/* adc_cfg_pkg.sv */
// converter interface and configuration types for the ADC sequencer
// one converter, two channels, results are 10 bits wide
// channel-select code 3 is never driven

`default_nettype none

package adc_cfg_pkg;

  // one converter result
  localparam int unsigned AdcDataWidth = 10;
  typedef logic [AdcDataWidth-1:0] adc_data_t;

  // match vector from the external filters
  localparam int unsigned NumAdcFilter = 8;
  typedef logic [NumAdcFilter-1:0] adc_match_t;

  // power-up wait, in aon clock cycles
  localparam int unsigned PwrupTimeWidth = 4;
  typedef logic [PwrupTimeWidth-1:0] pwrup_time_t;

  // stable-sample count for normal-power detection
  localparam int unsigned SampleCntWidth = 16;
  typedef logic [SampleCntWidth-1:0] sample_cnt_t;

  // channel select toward the converter
  typedef logic [1:0] adc_chn_sel_t;
  localparam adc_chn_sel_t ChnSelNone = 2'd0;
  localparam adc_chn_sel_t ChnSel0    = 2'd1;
  localparam adc_chn_sel_t ChnSel1    = 2'd2;

endpackage

`default_nettype wire
